// File: files.f
+incdir+tests
rtl/fft4_pkg.sv
rtl/butterfly_if.sv
rtl/cplx_butterfly.sv
rtl/fft4_ctrl.sv
rtl/fft4_top.sv
tests/fft4_tb.sv

// File: Makefile
TOP := fft4_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -f files.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)_sim
	out=$$(./obj_dir/$(TOP)_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: tests/fft4_ref.svh
`ifndef FFT4_REF_SVH
`define FFT4_REF_SVH

// pack two Q1.15 components into one sample
function automatic sample_t pack_sample(input comp_t re, input comp_t im);
    return {re, im};
endfunction

function automatic void unpack_sample(input sample_t s, output comp_t re, output comp_t im);
    re = s[SAMPLE_W-1:COMP_W];
    im = s[COMP_W-1:0];
endfunction

// floor(v / 2), the halving of every stage
function automatic int half_floor(input int v);
    if (v < 0 && (v % 2) != 0) begin
        return (v - 1) / 2;
    end
    return v / 2;
endfunction

// one butterfly a +/- b*W with the halving on both outputs
function automatic void butterfly_model(
    input  sample_t  a,
    input  sample_t  b,
    input  twiddle_t tw,
    output sample_t  sum,
    output sample_t  diff
);
    comp_t a_re;
    comp_t a_im;
    comp_t b_re;
    comp_t b_im;
    int    w_re;
    int    w_im;
    int    p_re;
    int    p_im;
    unpack_sample(a, a_re, a_im);
    unpack_sample(b, b_re, b_im);
    // W is 1 or -j
    w_re = (tw == TW_MINUS_J) ? 0 : 1;
    w_im = (tw == TW_MINUS_J) ? -1 : 0;
    // complex product b * W
    p_re = int'(b_re) * w_re - int'(b_im) * w_im;
    p_im = int'(b_re) * w_im + int'(b_im) * w_re;
    sum  = pack_sample(comp_t'(half_floor(int'(a_re) + p_re)),
                       comp_t'(half_floor(int'(a_im) + p_im)));
    diff = pack_sample(comp_t'(half_floor(int'(a_re) - p_re)),
                       comp_t'(half_floor(int'(a_im) - p_im)));
endfunction

// quarter-scaled 4-point DFT in natural order
function automatic void fft4_model(
    input  sample_t x0,
    input  sample_t x1,
    input  sample_t x2,
    input  sample_t x3,
    output sample_t y0,
    output sample_t y1,
    output sample_t y2,
    output sample_t y3
);
    sample_t s0;
    sample_t d0;
    sample_t s1;
    sample_t d1;
    butterfly_model(x0, x2, TW_ONE, s0, d0);
    butterfly_model(x1, x3, TW_ONE, s1, d1);
    butterfly_model(s0, s1, TW_ONE, y0, y2);
    butterfly_model(d0, d1, TW_MINUS_J, y1, y3);
endfunction

`endif

// File: tests/fft4_tb.sv
`timescale 1ns/1ps

module fft4_tb import fft4_pkg::*; ();

    `include "fft4_ref.svh"

    // cycles allowed for done to rise or fall
    localparam int WAIT_LIMIT = 20;

    logic    clk;
    logic    rst_n;
    logic    start;
    sample_t in0;
    sample_t in1;
    sample_t in2;
    sample_t in3;
    sample_t out0;
    sample_t out1;
    sample_t out2;
    sample_t out3;
    logic    done;

    fft4_top DUT (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .in0   (in0),
        .in1   (in1),
        .in2   (in2),
        .in3   (in3),
        .out0  (out0),
        .out1  (out1),
        .out2  (out2),
        .out3  (out3),
        .done  (done)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic check_equal(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h got %h",
                     $time, label, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_outputs(input string tag, input sample_t y0, input sample_t y1,
                                 input sample_t y2, input sample_t y3);
        check_equal($sformatf("%s out0", tag), y0, out0);
        check_equal($sformatf("%s out1", tag), y1, out1);
        check_equal($sformatf("%s out2", tag), y2, out2);
        check_equal($sformatf("%s out3", tag), y3, out3);
    endtask

    // counts edges after E0 until done is seen high
    task automatic wait_for_done(output int cycles);
        bit seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            seen = (done === 1'b1);
            // outputs stay zero until done
            if (!seen) begin
                check_outputs("before done", '0, '0, '0, '0);
            end
        end
        if (!seen) begin
            $display("done never rose within %0d cycles of start", WAIT_LIMIT);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout waiting for done");
        end
    endtask

    task automatic release_start(input string tag);
        int  cycles;
        bit  cleared;
        start = 1'b0;
        cycles = 0;
        cleared = 1'b0;
        while (!cleared && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
            cleared = (done === 1'b0);
        end
        if (!cleared) begin
            $display("done never fell after start dropped");
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout waiting for release");
        end
        // one edge back to IDLE, one edge to clear
        check_equal($sformatf("%s release cycles", tag), 32'd2, cycles);
        check_outputs($sformatf("%s released", tag), '0, '0, '0, '0);
    endtask

    // start one transform and compare against the reference; start stays high
    task automatic run_transform(input string tag, input sample_t x0, input sample_t x1,
                                 input sample_t x2, input sample_t x3);
        sample_t y0;
        sample_t y1;
        sample_t y2;
        sample_t y3;
        int      cycles;
        in0 = x0;
        in1 = x1;
        in2 = x2;
        in3 = x3;
        fft4_model(x0, x1, x2, x3, y0, y1, y2, y3);
        start = 1'b1;
        // this edge is E0
        @(posedge clk);
        wait_for_done(cycles);
        check_equal($sformatf("%s latency", tag), 32'd3, cycles);
        check_outputs(tag, y0, y1, y2, y3);
    endtask

    task automatic test_reset_state();
        repeat (5) begin
            @(posedge clk);
            #1;
            check_equal("reset done", 32'd0, 32'(done));
            check_outputs("reset", '0, '0, '0, '0);
        end
    endtask

    task automatic test_impulse();
        run_transform("impulse", pack_sample(16'sh4000, 16'sh0000), '0, '0, '0);
        // flat spectrum at one quarter of the impulse
        check_outputs("impulse literal", 32'h1000_0000, 32'h1000_0000,
                      32'h1000_0000, 32'h1000_0000);
        release_start("impulse");
    endtask

    task automatic test_const_alternating();
        run_transform("constant", 32'h2000_1000, 32'h2000_1000, 32'h2000_1000, 32'h2000_1000);
        check_outputs("constant bins", 32'h2000_1000, '0, '0, '0);
        release_start("constant");
        // x, -x, x, -x puts everything in bin 2
        run_transform("alternating", 32'h2000_1000, 32'hE000_F000,
                      32'h2000_1000, 32'hE000_F000);
        check_outputs("alternating bins", '0, '0, 32'h2000_1000, '0);
        release_start("alternating");
    endtask

    task automatic test_imag_extremes();
        run_transform("imag", '0, 32'h0000_4000, '0, '0);
        release_start("imag");
        run_transform("imag odd", 32'h0000_0001, 32'h0003_FFFF, 32'h0000_FFFD, 32'hFFFF_0005);
        release_start("imag odd");
        run_transform("extremes", 32'h8000_7FFF, 32'h7FFF_8000, 32'h8000_8000, 32'h7FFF_7FFF);
        release_start("extremes");
        run_transform("all min", 32'h8000_8000, 32'h8000_8000, 32'h8000_8000, 32'h8000_8000);
        release_start("all min");
        run_transform("min max mix", 32'h7FFF_8000, 32'h8000_8000, 32'h7FFF_7FFF, 32'h8000_7FFF);
        release_start("min max mix");
    endtask

    task automatic test_hold_release();
        sample_t held0;
        sample_t held1;
        sample_t held2;
        sample_t held3;
        run_transform("hold", 32'h1234_F00D, 32'hC001_0ABC, 32'h7F00_8100, 32'h0042_FFBE);
        held0 = out0;
        held1 = out1;
        held2 = out2;
        held3 = out3;
        repeat (10) begin
            @(posedge clk);
            #1;
            check_equal("hold done", 32'd1, 32'(done));
            check_outputs("hold", held0, held1, held2, held3);
        end
        release_start("hold");
    endtask

    task automatic test_random();
        for (int i = 0; i < 40; i++) begin
            run_transform($sformatf("random %0d", i), $urandom(), $urandom(),
                          $urandom(), $urandom());
            release_start($sformatf("random %0d", i));
        end
    endtask

    initial begin
        void'($urandom(47));
        clk   = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        in0   = '0;
        in1   = '0;
        in2   = '0;
        in3   = '0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_impulse();
        test_const_alternating();
        test_imag_extremes();
        test_hold_release();
        test_random();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: rtl/fft4_top.sv
`timescale 1ns/1ps

module fft4_top import fft4_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  sample_t in0,
    input  sample_t in1,
    input  sample_t in2,
    input  sample_t in3,
    output sample_t out0,
    output sample_t out1,
    output sample_t out2,
    output sample_t out3,
    output logic    done
);

    // one bundle per shared butterfly
    butterfly_if bf0_if ();
    butterfly_if bf1_if ();

    // sequencing and result registers
    fft4_ctrl u_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .in0   (in0),
        .in1   (in1),
        .in2   (in2),
        .in3   (in3),
        .out0  (out0),
        .out1  (out1),
        .out2  (out2),
        .out3  (out3),
        .done  (done),
        .bf0   (bf0_if.ctrl),
        .bf1   (bf1_if.ctrl)
    );

    // bf0 takes the even pair in stage 1 and the sums in stage 2
    cplx_butterfly bf0 (
        .bf (bf0_if.unit)
    );

    // bf1 takes the odd pair in stage 1 and the differences in stage 2
    cplx_butterfly bf1 (
        .bf (bf1_if.unit)
    );

endmodule

// File: rtl/fft4_ctrl.sv
`timescale 1ns/1ps

module fft4_ctrl import fft4_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    input  sample_t          in0,
    input  sample_t          in1,
    input  sample_t          in2,
    input  sample_t          in3,
    output sample_t          out0,
    output sample_t          out1,
    output sample_t          out2,
    output sample_t          out3,
    output logic             done,
    butterfly_if.ctrl        bf0,
    butterfly_if.ctrl        bf1
);

    fft_state_t state;
    fft_state_t state_next;

    // operand registers feeding the two butterflies
    sample_t  a0_q;
    sample_t  b0_q;
    twiddle_t tw0_q;
    sample_t  a1_q;
    sample_t  b1_q;
    twiddle_t tw1_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = STAGE_1;
                end
            end
            STAGE_1: begin
                state_next = STAGE_2;
            end
            STAGE_2: begin
                state_next = DONE;
            end
            DONE: begin
                // hold the result until the source drops start
                if (!start) begin
                    state_next = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        case (state)
            STAGE_1: begin
                // first stage pairs x0/x2 and x1/x3
                a0_q  <= in0;
                b0_q  <= in2;
                tw0_q <= TW_ONE;
                a1_q  <= in1;
                b1_q  <= in3;
                tw1_q <= TW_ONE;
            end
            STAGE_2: begin
                // sums combine with 1, differences with -j
                a0_q  <= bf0.sum;
                b0_q  <= bf1.sum;
                tw0_q <= TW_ONE;
                a1_q  <= bf0.diff;
                b1_q  <= bf1.diff;
                tw1_q <= TW_MINUS_J;
            end
            default: begin
                a0_q  <= a0_q;
                b0_q  <= b0_q;
                tw0_q <= tw0_q;
                a1_q  <= a1_q;
                b1_q  <= b1_q;
                tw1_q <= tw1_q;
            end
        endcase
    end

    assign bf0.a  = a0_q;
    assign bf0.b  = b0_q;
    assign bf0.tw = tw0_q;
    assign bf1.a  = a1_q;
    assign bf1.b  = b1_q;
    assign bf1.tw = tw1_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
            out0 <= '0;
            out1 <= '0;
            out2 <= '0;
            out3 <= '0;
        end else begin
            case (state)
                IDLE: begin
                    done <= 1'b0;
                    out0 <= '0;
                    out1 <= '0;
                    out2 <= '0;
                    out3 <= '0;
                end
                DONE: begin
                    // natural order X0..X3
                    done <= 1'b1;
                    out0 <= bf0.sum;
                    out1 <= bf1.sum;
                    out2 <= bf0.diff;
                    out3 <= bf1.diff;
                end
                default: begin
                    done <= done;
                    out0 <= out0;
                    out1 <= out1;
                    out2 <= out2;
                    out3 <= out3;
                end
            endcase
        end
    end

    // done only follows a cycle spent in DONE
    done_after_done_state: assert property (
        @(posedge clk) disable iff (!rst_n)
        done |-> ($past(state) == DONE)
    ) else $error("done high without DONE state in previous cycle");

    // start taken in IDLE at E0, done set at E0+3,
    // seen high at the edge after that
    done_rise_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(start && (state == IDLE), 4)
    ) else $error("done rose without start in IDLE three cycles earlier");

    // synchronous reset clears done
    done_low_after_reset: assert property (
        @(posedge clk)
        !rst_n |=> !done
    ) else $error("done high in the cycle after reset");

endmodule

// File: rtl/cplx_butterfly.sv
`timescale 1ns/1ps

module cplx_butterfly import fft4_pkg::*; (
    butterfly_if.unit bf
);

    comp_t a_re;
    comp_t a_im;
    comp_t b_re;
    comp_t b_im;

    // b times the twiddle, widened
    wide_t p_re;
    wide_t p_im;

    // full precision sum and difference
    wide_t sum_re_w;
    wide_t sum_im_w;
    wide_t diff_re_w;
    wide_t diff_im_w;

    // halved results
    comp_t sum_re;
    comp_t sum_im;
    comp_t diff_re;
    comp_t diff_im;

    assign a_re = bf.a[SAMPLE_W-1:COMP_W];
    assign a_im = bf.a[COMP_W-1:0];
    assign b_re = bf.b[SAMPLE_W-1:COMP_W];
    assign b_im = bf.b[COMP_W-1:0];

    // twiddle product without a multiplier
    // (br + j*bi) * (-j) = bi - j*br
    always_comb begin
        if (bf.tw == TW_MINUS_J) begin
            p_re = wide_t'(b_im);
            p_im = -wide_t'(b_re);
        end else begin
            p_re = wide_t'(b_re);
            p_im = wide_t'(b_im);
        end
    end

    assign sum_re_w  = wide_t'(a_re) + p_re;
    assign sum_im_w  = wide_t'(a_im) + p_im;
    assign diff_re_w = wide_t'(a_re) - p_re;
    assign diff_im_w = wide_t'(a_im) - p_im;

    // arithmetic shift, rounds toward minus infinity
    assign sum_re  = comp_t'(sum_re_w >>> 1);
    assign sum_im  = comp_t'(sum_im_w >>> 1);
    assign diff_re = comp_t'(diff_re_w >>> 1);
    assign diff_im = comp_t'(diff_im_w >>> 1);

    assign bf.sum  = {sum_re, sum_im};
    assign bf.diff = {diff_re, diff_im};

    // the controller loads operands and twiddle together,
    // so a known operand never meets an unknown select
    always_comb begin
        if (!$isunknown(bf.a)) begin
            assert (!$isunknown(bf.tw))
                else $error("butterfly twiddle unknown with known operand");
        end
    end

endmodule

// File: rtl/butterfly_if.sv
`timescale 1ns/1ps

interface butterfly_if import fft4_pkg::*; ();

    // operands and twiddle select
    sample_t  a;
    sample_t  b;
    twiddle_t tw;

    // results, valid in the same cycle as the operands
    sample_t  sum;
    sample_t  diff;

    modport ctrl (
        output a,
        output b,
        output tw,
        input  sum,
        input  diff
    );

    modport unit (
        input  a,
        input  b,
        input  tw,
        output sum,
        output diff
    );

endinterface

// File: rtl/fft4_pkg.sv
package fft4_pkg;

    // one real or imaginary component
    localparam int COMP_W = 16;

    // packed complex sample, real half on top
    localparam int SAMPLE_W = 2 * COMP_W;

    // signed Q1.15 component
    typedef logic signed [COMP_W-1:0] comp_t;

    // one guard bit so a sum or difference of two components never wraps
    typedef logic signed [COMP_W:0] wide_t;

    // real part in bits 31..16, imaginary part in bits 15..0
    typedef logic [SAMPLE_W-1:0] sample_t;

    // twiddle select for the 4-point transform
    typedef logic [0:0] twiddle_t;

    localparam twiddle_t TW_ONE     = 1'b0;
    localparam twiddle_t TW_MINUS_J = 1'b1;

    // controller sequence
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        STAGE_1 = 2'd1,
        STAGE_2 = 2'd2,
        DONE    = 2'd3
    } fft_state_t;

endpackage
